// ==== Bender.yml ====
package:
  name: la_id_stage

sources:
  - include_dirs:
      - hw
    files:
      - hw/la_id_pkg.sv
      - hw/id_latch.sv
      - hw/inst_decoder.sv
      - hw/operand_fetch.sv
      - hw/id_issue.sv
      - hw/id_top.sv

  - target: test
    include_dirs:
      - hw
    files:
      - verification/id_assert.sv
      - verification/tb_id_top.sv

// ==== hw/id_issue.sv ====
`timescale 1ns/1ns

module id_issue import la_id_pkg::*; (
    input  logic        ds_valid,
    input  logic [31:0] pc,
    input  dec_ctl_t    ctl,
    input  opnd_t       opnd,
    input  hz_t         hz,
    input  logic        es_res_from_mem,
    output logic        ready,
    output logic        ds_to_es_valid,
    output br_res_t     br,
    output ds_to_es_t   ds_to_es_bus
);

    logic [31:0] rj;
    logic [31:0] rkd;
    logic        rj_eq_rkd;
    logic        rj_lt_s;
    logic        rj_lt_u;
    logic [8:0]  cond;
    logic        load_use;

    assign rj  = opnd.rj_value;
    assign rkd = opnd.rkd_value;

    // branch compare
    assign rj_eq_rkd = (rj == rkd);
    assign rj_lt_s   = ($signed(rj) < $signed(rkd));
    assign rj_lt_u   = (rj < rkd);

    // one bit per br_kind, unconditional jumps always pass
    always_comb begin
        cond          = '0;
        cond[BR_BEQ]  = rj_eq_rkd;
        cond[BR_BNE]  = ~rj_eq_rkd;
        cond[BR_BLT]  = rj_lt_s;
        cond[BR_BGE]  = ~rj_lt_s;
        cond[BR_BLTU] = rj_lt_u;
        cond[BR_BGEU] = ~rj_lt_u;
        cond[BR_B]    = 1'b1;
        cond[BR_BL]   = 1'b1;
        cond[BR_JIRL] = 1'b1;
    end

    // loaded value is not there yet
    assign load_use = es_res_from_mem &
                      ((hz.ex_hit_r1 & ctl.need_r1) | (hz.ex_hit_r2 & ctl.need_r2));

    assign ready          = ~load_use;
    assign ds_to_es_valid = ds_valid & ready;

    // operands are only trusted once the stall is gone
    assign br.taken  = ds_valid & ready & (|(ctl.br_kind & cond));
    assign br.target = ctl.is_jirl ? (rj + ctl.br_offs) : (pc + ctl.br_offs);

    always_comb begin
        ds_to_es_bus.alu_op       = ctl.alu_op;
        ds_to_es_bus.res_from_mem = ctl.res_from_mem;
        ds_to_es_bus.alu_src1     = ctl.src1_is_pc ? pc : rj;
        ds_to_es_bus.alu_src2     = ctl.src2_is_imm ? ctl.imm : rkd;
        ds_to_es_bus.mem_we       = ctl.mem_we;
        ds_to_es_bus.rf_we        = ctl.rf_we;
        ds_to_es_bus.rf_waddr     = ctl.dest;
        ds_to_es_bus.rkd_value    = rkd;
        ds_to_es_bus.pc           = pc;
    end

endmodule

// ==== hw/id_latch.sv ====
`timescale 1ns/1ns

module id_latch import la_id_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic        fs_to_ds_valid,
    input  fetch_pkt_t  fs_to_ds_bus,
    input  logic        es_allowin,
    input  logic        ready,
    input  logic        br_taken,
    output logic        ds_allowin,
    output logic        ds_valid,
    output logic [31:0] inst,
    output logic [31:0] pc
);

    logic accept;

    // empty, or the held instruction leaves this cycle
    assign ds_allowin = ~ds_valid | (ready & es_allowin);
    assign accept     = fs_to_ds_valid & ds_allowin;

    // flush wins over a new transfer
    always_ff @(posedge clk) begin
        if (!resetn) begin
            ds_valid <= 1'b0;
        end else if (br_taken) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            inst <= 32'b0;
            pc   <= 32'b0;
        end else if (accept) begin
            inst <= fs_to_ds_bus.inst;
            pc   <= fs_to_ds_bus.pc;
        end
    end

endmodule

// ==== hw/id_top.sv ====
`timescale 1ns/1ns

module id_top import la_id_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    // fetch side
    input  logic       fs_to_ds_valid,
    output logic       ds_allowin,
    input  fetch_pkt_t fs_to_ds_bus,
    // execute side
    input  logic       es_allowin,
    output logic       ds_to_es_valid,
    output ds_to_es_t  ds_to_es_bus,
    output br_res_t    br_collect,
    // producers in later stages
    input  wb_fwd_t    ws_rf_collect,
    input  wb_fwd_t    ms_rf_collect,
    input  ex_fwd_t    es_rf_collect
);

    logic        ds_valid;
    logic [31:0] inst;
    logic [31:0] pc;
    logic        ready;
    dec_ctl_t    ctl;
    opnd_t       opnd;
    hz_t         hz;

    id_latch u_latch (
        .clk            (clk),
        .resetn         (resetn),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .es_allowin     (es_allowin),
        .ready          (ready),
        .br_taken       (br_collect.taken),
        .ds_allowin     (ds_allowin),
        .ds_valid       (ds_valid),
        .inst           (inst),
        .pc             (pc)
    );

    inst_decoder u_dec (
        .inst     (inst),
        .ds_valid (ds_valid),
        .ctl      (ctl)
    );

    operand_fetch u_opnd (
        .clk  (clk),
        .rs1  (ctl.rs1),
        .rs2  (ctl.rs2),
        .ws   (ws_rf_collect),
        .ms   (ms_rf_collect),
        .es   (es_rf_collect),
        .opnd (opnd),
        .hz   (hz)
    );

    id_issue u_issue (
        .ds_valid        (ds_valid),
        .pc              (pc),
        .ctl             (ctl),
        .opnd            (opnd),
        .hz              (hz),
        .es_res_from_mem (es_rf_collect.res_from_mem),
        .ready           (ready),
        .ds_to_es_valid  (ds_to_es_valid),
        .br              (br_collect),
        .ds_to_es_bus    (ds_to_es_bus)
    );

endmodule

// ==== hw/inst_decoder.sv ====
`timescale 1ns/1ns
`include "la_id_params.svh"

module inst_decoder import la_id_pkg::*; (
    input  logic [31:0] inst,
    input  logic        ds_valid,
    output dec_ctl_t    ctl
);

    logic [5:0]  op_31_26;
    logic [3:0]  op_25_22;
    logic [1:0]  op_21_20;
    logic [4:0]  op_19_15;
    logic [4:0]  rd, rj, rk;
    logic [11:0] i12;
    logic [19:0] i20;
    logic [15:0] i16;
    logic [25:0] i26;

    logic grp_alu, grp_3r, grp_div, grp_shi, grp_mem;
    logic is_add_w, is_sub_w, is_slt, is_sltu, is_nor, is_and, is_or, is_xor;
    logic is_sll_w, is_srl_w, is_sra_w, is_slli_w, is_srli_w, is_srai_w;
    logic is_addi_w, is_slti, is_sltui, is_andi, is_ori, is_xori;
    logic is_lu12i_w, is_pcaddu12i;
    logic is_mul_w, is_mulh_w, is_mulh_wu, is_div_w, is_mod_w, is_div_wu, is_mod_wu;
    logic is_ld_b, is_ld_h, is_ld_w, is_ld_bu, is_st_b, is_st_h, is_st_w, is_ld, is_st;
    logic is_jirl, is_b, is_bl, is_beq, is_bne, is_blt, is_bge, is_bltu, is_bgeu, is_cbr;
    logic need_ui5, need_ui12, need_si12, need_si20, need_si26, src2_is_4;
    logic src1_is_pc, src2_is_imm;
    logic [`LA_AOP_W-1:0] aop;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];
    assign rd  = inst[4:0];
    assign rj  = inst[9:5];
    assign rk  = inst[14:10];
    assign i12 = inst[21:10];
    assign i20 = inst[24:5];
    assign i16 = inst[25:10];
    assign i26 = {inst[9:0], inst[25:10]};

    assign grp_alu = (op_31_26 == `LA_OP_ALU);
    assign grp_3r  = grp_alu && (op_25_22 == 4'h0) && (op_21_20 == 2'h1);
    assign grp_div = grp_alu && (op_25_22 == 4'h0) && (op_21_20 == 2'h2);
    assign grp_shi = grp_alu && (op_25_22 == 4'h1) && (op_21_20 == 2'h0);
    assign grp_mem = (op_31_26 == `LA_OP_MEM);

    assign is_add_w   = grp_3r && (op_19_15 == 5'h00);
    assign is_sub_w   = grp_3r && (op_19_15 == 5'h02);
    assign is_slt     = grp_3r && (op_19_15 == 5'h04);
    assign is_sltu    = grp_3r && (op_19_15 == 5'h05);
    assign is_nor     = grp_3r && (op_19_15 == 5'h08);
    assign is_and     = grp_3r && (op_19_15 == 5'h09);
    assign is_or      = grp_3r && (op_19_15 == 5'h0a);
    assign is_xor     = grp_3r && (op_19_15 == 5'h0b);
    assign is_sll_w   = grp_3r && (op_19_15 == 5'h0e);
    assign is_srl_w   = grp_3r && (op_19_15 == 5'h0f);
    assign is_sra_w   = grp_3r && (op_19_15 == 5'h10);
    assign is_mul_w   = grp_3r && (op_19_15 == 5'h18);
    assign is_mulh_w  = grp_3r && (op_19_15 == 5'h19);
    assign is_mulh_wu = grp_3r && (op_19_15 == 5'h1a);
    assign is_div_w   = grp_div && (op_19_15 == 5'h00);
    assign is_mod_w   = grp_div && (op_19_15 == 5'h01);
    assign is_div_wu  = grp_div && (op_19_15 == 5'h02);
    assign is_mod_wu  = grp_div && (op_19_15 == 5'h03);
    assign is_slli_w  = grp_shi && (op_19_15 == 5'h01);
    assign is_srli_w  = grp_shi && (op_19_15 == 5'h09);
    assign is_srai_w  = grp_shi && (op_19_15 == 5'h11);

    assign is_slti   = grp_alu && (op_25_22 == 4'h8);
    assign is_sltui  = grp_alu && (op_25_22 == 4'h9);
    assign is_addi_w = grp_alu && (op_25_22 == 4'ha);
    assign is_andi   = grp_alu && (op_25_22 == 4'hd);
    assign is_ori    = grp_alu && (op_25_22 == 4'he);
    assign is_xori   = grp_alu && (op_25_22 == 4'hf);

    assign is_lu12i_w   = (inst[31:25] == `LA_OP_LU12I);
    assign is_pcaddu12i = (inst[31:25] == `LA_OP_PCADDU12I);

    assign is_ld_b  = grp_mem && (op_25_22 == 4'h0);
    assign is_ld_h  = grp_mem && (op_25_22 == 4'h1);
    assign is_ld_w  = grp_mem && (op_25_22 == 4'h2);
    assign is_st_b  = grp_mem && (op_25_22 == 4'h4);
    assign is_st_h  = grp_mem && (op_25_22 == 4'h5);
    assign is_st_w  = grp_mem && (op_25_22 == 4'h6);
    assign is_ld_bu = grp_mem && (op_25_22 == 4'h8);
    assign is_ld    = is_ld_b | is_ld_h | is_ld_w | is_ld_bu;
    assign is_st    = is_st_b | is_st_h | is_st_w;

    assign is_jirl = (op_31_26 == `LA_OP_JIRL);
    assign is_b    = (op_31_26 == `LA_OP_B);
    assign is_bl   = (op_31_26 == `LA_OP_BL);
    assign is_beq  = (op_31_26 == `LA_OP_BEQ);
    assign is_bne  = (op_31_26 == `LA_OP_BNE);
    assign is_blt  = (op_31_26 == `LA_OP_BLT);
    assign is_bge  = (op_31_26 == `LA_OP_BGE);
    assign is_bltu = (op_31_26 == `LA_OP_BLTU);
    assign is_bgeu = (op_31_26 == `LA_OP_BGEU);
    assign is_cbr  = is_beq | is_bne | is_blt | is_bge | is_bltu | is_bgeu;

    // link and address math both go through add
    assign aop[11:0] = {is_lu12i_w, is_sra_w | is_srai_w, is_srl_w | is_srli_w,
                        is_sll_w | is_slli_w, is_xor | is_xori, is_or | is_ori, is_nor,
                        is_and | is_andi, is_sltu | is_sltui, is_slt | is_slti, is_sub_w,
                        is_add_w | is_addi_w | is_ld | is_st | is_jirl | is_bl | is_pcaddu12i};
    assign aop[18:12] = {is_mul_w, is_mulh_w, is_mulh_wu, is_div_w, is_mod_w,
                         is_div_wu, is_mod_wu};

    assign need_ui5    = is_slli_w | is_srli_w | is_srai_w;
    assign need_ui12   = is_andi | is_ori | is_xori;
    assign need_si12   = is_slti | is_sltui | is_addi_w | is_ld | is_st;
    assign need_si20   = is_lu12i_w | is_pcaddu12i;
    assign need_si26   = is_b | is_bl;
    assign src2_is_4   = is_jirl | is_bl;
    assign src1_is_pc  = is_jirl | is_bl | is_pcaddu12i;
    assign src2_is_imm = need_ui5 | need_ui12 | need_si12 | need_si20 | src2_is_4;

    always_comb begin
        ctl.alu_op       = aop;
        ctl.src1_is_pc   = src1_is_pc;
        ctl.src2_is_imm  = src2_is_imm;
        ctl.res_from_mem = is_ld;
        ctl.mem_we       = ds_valid & is_st;
        ctl.rf_we        = ds_valid & (|aop) & ~is_st;
        ctl.dest         = is_bl ? 5'd1 : rd;
        ctl.rs1          = rj;
        // branches and stores read rd as the second source
        ctl.rs2          = (is_cbr | is_st) ? rd : rk;
        ctl.need_r1      = ((|aop) & ~src1_is_pc & ~is_lu12i_w) | is_cbr | is_jirl;
        ctl.need_r2      = ((|aop) & ~src2_is_imm) | is_cbr | is_st;
        ctl.imm          = src2_is_4 ? 32'h4 :
                           need_si20 ? {i20, 12'b0} :
                           need_ui5  ? {27'b0, rk} :
                           need_ui12 ? {20'b0, i12} : {{20{i12[11]}}, i12};
        ctl.br_offs      = need_si26 ? {{4{i26[25]}}, i26, 2'b0} : {{14{i16[15]}}, i16, 2'b0};
        ctl.br_kind      = {is_jirl, is_bl, is_b, is_bgeu, is_bltu, is_bge, is_blt,
                            is_bne, is_beq};
        ctl.is_jirl      = is_jirl;
    end

endmodule

// ==== hw/la_id_params.svh ====
`ifndef LA_ID_PARAMS_SVH
`define LA_ID_PARAMS_SVH

// datapath and register file
`define LA_XLEN   32
`define LA_NREG   32

// twelve base ops plus seven mul/div ops
`define LA_AOP_W  19

// major opcodes, inst[31:26]
`define LA_OP_ALU   6'h00
`define LA_OP_MEM   6'h0a
`define LA_OP_JIRL  6'h13
`define LA_OP_B     6'h14
`define LA_OP_BL    6'h15
`define LA_OP_BEQ   6'h16
`define LA_OP_BNE   6'h17
`define LA_OP_BLT   6'h18
`define LA_OP_BGE   6'h19
`define LA_OP_BLTU  6'h1a
`define LA_OP_BGEU  6'h1b

// 7-bit opcodes, inst[31:25]
`define LA_OP_LU12I     7'h0a
`define LA_OP_PCADDU12I 7'h0e

`endif

// ==== hw/la_id_pkg.sv ====
package la_id_pkg;

    // bit positions inside dec_ctl_t.br_kind
    localparam int BR_BEQ  = 0;
    localparam int BR_BNE  = 1;
    localparam int BR_BLT  = 2;
    localparam int BR_BGE  = 3;
    localparam int BR_BLTU = 4;
    localparam int BR_BGEU = 5;
    localparam int BR_B    = 6;
    localparam int BR_BL   = 7;
    localparam int BR_JIRL = 8;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
    } fetch_pkt_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] wdata;
    } wb_fwd_t;

    // execute result may still be a load address
    typedef struct packed {
        logic        res_from_mem;
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] wdata;
    } ex_fwd_t;

    typedef struct packed {
        logic [18:0] alu_op;
        logic        src1_is_pc;
        logic        src2_is_imm;
        logic        res_from_mem;
        logic        mem_we;
        logic        rf_we;
        logic [4:0]  dest;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        need_r1;
        logic        need_r2;
        logic [31:0] imm;
        logic [31:0] br_offs;
        logic [8:0]  br_kind;
        logic        is_jirl;
    } dec_ctl_t;

    typedef struct packed {
        logic [31:0] rj_value;
        logic [31:0] rkd_value;
    } opnd_t;

    typedef struct packed {
        logic ex_hit_r1;
        logic ex_hit_r2;
    } hz_t;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } br_res_t;

    typedef struct packed {
        logic [18:0] alu_op;
        logic        res_from_mem;
        logic [31:0] alu_src1;
        logic [31:0] alu_src2;
        logic        mem_we;
        logic        rf_we;
        logic [4:0]  rf_waddr;
        logic [31:0] rkd_value;
        logic [31:0] pc;
    } ds_to_es_t;

endpackage

// ==== hw/operand_fetch.sv ====
`timescale 1ns/1ns
`include "la_id_params.svh"

module operand_fetch import la_id_pkg::*; (
    input  logic       clk,
    input  logic [4:0] rs1,
    input  logic [4:0] rs2,
    input  wb_fwd_t    ws,
    input  wb_fwd_t    ms,
    input  ex_fwd_t    es,
    output opnd_t      opnd,
    output hz_t        hz
);

    logic [`LA_XLEN-1:0] regs [`LA_NREG];
    logic [`LA_XLEN-1:0] rf_rdata1;
    logic [`LA_XLEN-1:0] rf_rdata2;
    logic                es_hit1, es_hit2;
    logic                ms_hit1, ms_hit2;
    logic                ws_hit1, ws_hit2;

    // a write to r0 never counts as a producer
    function automatic logic fwd_hit(
        input logic       we,
        input logic [4:0] waddr,
        input logic [4:0] raddr
    );
        return we && (raddr != 5'd0) && (waddr == raddr);
    endfunction

    always_ff @(posedge clk) begin
        if (ws.we && (ws.waddr != 5'd0)) begin
            regs[ws.waddr] <= ws.wdata;
        end
    end

    // r0 is hardwired
    assign rf_rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rf_rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

    assign es_hit1 = fwd_hit(es.we, es.waddr, rs1);
    assign es_hit2 = fwd_hit(es.we, es.waddr, rs2);
    assign ms_hit1 = fwd_hit(ms.we, ms.waddr, rs1);
    assign ms_hit2 = fwd_hit(ms.we, ms.waddr, rs2);
    assign ws_hit1 = fwd_hit(ws.we, ws.waddr, rs1);
    assign ws_hit2 = fwd_hit(ws.we, ws.waddr, rs2);

    // youngest producer first
    always_comb begin
        if (es_hit1) begin
            opnd.rj_value = es.wdata;
        end else if (ms_hit1) begin
            opnd.rj_value = ms.wdata;
        end else if (ws_hit1) begin
            opnd.rj_value = ws.wdata;
        end else begin
            opnd.rj_value = rf_rdata1;
        end
    end

    always_comb begin
        if (es_hit2) begin
            opnd.rkd_value = es.wdata;
        end else if (ms_hit2) begin
            opnd.rkd_value = ms.wdata;
        end else if (ws_hit2) begin
            opnd.rkd_value = ws.wdata;
        end else begin
            opnd.rkd_value = rf_rdata2;
        end
    end

    // execute matches feed the load-use check
    assign hz.ex_hit_r1 = es_hit1;
    assign hz.ex_hit_r2 = es_hit2;

endmodule

// ==== tb.f ====
+incdir+hw
hw/la_id_pkg.sv
hw/id_latch.sv
hw/inst_decoder.sv
hw/operand_fetch.sv
hw/id_issue.sv
hw/id_top.sv
verification/id_assert.sv
verification/tb_id_top.sv

// ==== verification/id_assert.sv ====
`timescale 1ns/1ns

module id_assert import la_id_pkg::*; (
    input logic      clk,
    input logic      resetn,
    input logic      ds_valid,
    input logic      ds_to_es_valid,
    input logic      es_allowin,
    input ds_to_es_t ds_to_es_bus,
    input br_res_t   br_collect
);

    int n_fail = 0;

    // nothing leaves an empty stage
    valid_needs_occupancy: assert property (@(posedge clk) disable iff (!resetn)
        !ds_valid |-> !ds_to_es_valid)
        else begin
            n_fail = n_fail + 1;
            $error("ds_to_es_valid high while the stage is empty");
        end

    // held bundle under back-pressure
    bundle_held: assert property (@(posedge clk) disable iff (!resetn)
        (ds_to_es_valid && !es_allowin && !br_collect.taken) |=> $stable(ds_to_es_bus))
        else begin
            n_fail = n_fail + 1;
            $error("ds_to_es_bus changed while execute was not accepting");
        end

    flush_clears_valid: assert property (@(posedge clk) disable iff (!resetn)
        br_collect.taken |=> !ds_valid)
        else begin
            n_fail = n_fail + 1;
            $error("ds_valid still high after a taken branch");
        end

endmodule

bind id_top id_assert u_assert (
    .clk            (clk),
    .resetn         (resetn),
    .ds_valid       (ds_valid),
    .ds_to_es_valid (ds_to_es_valid),
    .es_allowin     (es_allowin),
    .ds_to_es_bus   (ds_to_es_bus),
    .br_collect     (br_collect)
);

// ==== verification/tb_id_top.sv ====
`timescale 1ns/1ns
`include "la_id_params.svh"

module tb_id_top import la_id_pkg::*; ();

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
        wb_fwd_t     ws;
        wb_fwd_t     ms;
        ex_fwd_t     es;
        logic        eal;
        logic [18:0] aop;
        logic [31:0] imm;
        // src1 pc / src2 imm / rf_we / mem_we / res_from_mem
        logic [4:0]  flags;
        logic [4:0]  waddr;
    } row_t;

    typedef struct packed {
        logic [31:0] src1;
        logic [31:0] src2;
        logic [31:0] rkd;
        logic [31:0] target;
        logic        taken;
        logic        stall;
    } pred_t;

    localparam logic [4:0] F_NONE = 5'b00000;
    localparam logic [4:0] F_R    = 5'b00100;
    localparam logic [4:0] F_I    = 5'b01100;
    localparam logic [4:0] F_LD   = 5'b01101;
    localparam logic [4:0] F_ST   = 5'b01010;
    localparam logic [4:0] F_LINK = 5'b11100;
    localparam logic [31:0] M1    = 32'hffff_ffff;

    logic       clk;
    logic       resetn;
    logic       fs_to_ds_valid;
    logic       ds_allowin;
    fetch_pkt_t fs_to_ds_bus;
    logic       es_allowin;
    logic       ds_to_es_valid;
    ds_to_es_t  ds_to_es_bus;
    br_res_t    br_collect;
    wb_fwd_t    ws_rf_collect;
    wb_fwd_t    ms_rf_collect;
    ex_fwd_t    es_rf_collect;

    logic [31:0] shadow [`LA_NREG];
    row_t        tbl [64];
    int          n_rows = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    int          cycles = 0;
    int          limit = 0;
    int unsigned seed = 32'hfd391bbf;

    // the last four 3R ops sit in the div group
    logic [4:0] op3 [18] = '{5'h00, 5'h02, 5'h04, 5'h05, 5'h08, 5'h09, 5'h0a, 5'h0b, 5'h0e,
                             5'h0f, 5'h10, 5'h18, 5'h19, 5'h1a, 5'h00, 5'h01, 5'h02, 5'h03};
    int         idx3 [18] = '{0, 1, 2, 3, 5, 4, 6, 7, 8, 9, 10, 18, 17, 16, 15, 14, 13, 12};
    logic [3:0] opi  [6]  = '{4'h8, 4'h9, 4'ha, 4'hd, 4'he, 4'hf};
    int         idxi [6]  = '{2, 3, 0, 4, 6, 7};
    logic [4:0] ops  [3]  = '{5'h01, 5'h09, 5'h11};
    logic [3:0] opm  [7]  = '{4'h0, 4'h1, 4'h2, 4'h8, 4'h4, 4'h5, 4'h6};
    // taken and not-taken pairs per branch kind starting at beq
    logic [31:0] bra [12] = '{5, 5, 5, 5, M1, 1, 1, M1, 1, M1, M1, 1};
    logic [31:0] brb [12] = '{5, 6, 6, 5, 1, M1, M1, 1, M1, 1, 1, M1};

    id_top UUT (
        .clk            (clk),
        .resetn         (resetn),
        .fs_to_ds_valid (fs_to_ds_valid),
        .ds_allowin     (ds_allowin),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .es_allowin     (es_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .br_collect     (br_collect),
        .ws_rf_collect  (ws_rf_collect),
        .ms_rf_collect  (ms_rf_collect),
        .es_rf_collect  (es_rf_collect)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout: test did not finish within %0d cycles", limit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] r3_inst(input logic [1:0] grp, input logic [4:0] op,
                                            input logic [4:0] rd, input logic [4:0] rj,
                                            input logic [4:0] rk);
        return {6'h00, 4'h0, grp, op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] ri12_inst(input logic [5:0] major, input logic [3:0] op,
                                              input logic [11:0] i12, input logic [4:0] rj,
                                              input logic [4:0] rd);
        return {major, op, i12, rj, rd};
    endfunction

    function automatic logic [31:0] ri20_inst(input logic [6:0] op, input logic [19:0] i20,
                                              input logic [4:0] rd);
        return {op, i20, rd};
    endfunction

    function automatic logic [31:0] br16_inst(input logic [5:0] op, input logic [15:0] offs,
                                              input logic [4:0] rj, input logic [4:0] rd);
        return {op, offs, rj, rd};
    endfunction

    function automatic logic [31:0] br26_inst(input logic [5:0] op, input logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    // youngest producer wins and r0 never forwards
    function automatic logic [31:0] src_value(input logic [4:0] a, input row_t r,
                                              input ex_fwd_t es);
        if (a == 5'd0) return 32'd0;
        if (es.we && es.waddr == a) return es.wdata;
        if (r.ms.we && r.ms.waddr == a) return r.ms.wdata;
        if (r.ws.we && r.ws.waddr == a) return r.ws.wdata;
        return shadow[a];
    endfunction

    function automatic pred_t predict(input row_t r, input ex_fwd_t es);
        pred_t       e;
        logic [5:0]  op;
        logic [4:0]  a1;
        logic [4:0]  a2;
        logic [31:0] rj;
        logic [31:0] offs;
        logic        cbr;
        logic        st;
        logic        n1;
        logic        n2;
        op  = r.inst[31:26];
        cbr = (op >= `LA_OP_BEQ) && (op <= `LA_OP_BGEU);
        st  = (op == `LA_OP_MEM) && (r.inst[25:24] == 2'b01) && (r.inst[23:22] != 2'b11);
        a1  = r.inst[9:5];
        a2  = (cbr || st) ? r.inst[4:0] : r.inst[14:10];
        rj  = src_value(a1, r, es);
        e.rkd   = src_value(a2, r, es);
        // sources the instruction really reads, lu12i.w reads none
        n1  = cbr || (op == `LA_OP_JIRL) ||
              ((r.aop != 19'd0) && !r.flags[4] && !r.aop[11]);
        n2  = cbr || st || ((r.aop != 19'd0) && !r.flags[3]);
        e.stall = es.res_from_mem && es.we &&
                  ((n1 && a1 != 5'd0 && es.waddr == a1) ||
                   (n2 && a2 != 5'd0 && es.waddr == a2));
        e.src1  = r.flags[4] ? r.pc : rj;
        e.src2  = r.flags[3] ? r.imm : e.rkd;
        if (op == `LA_OP_B || op == `LA_OP_BL) begin
            offs = {{4{r.inst[9]}}, r.inst[9:0], r.inst[25:10], 2'b00};
        end else begin
            offs = {{14{r.inst[25]}}, r.inst[25:10], 2'b00};
        end
        case (op)
            `LA_OP_JIRL, `LA_OP_B, `LA_OP_BL: e.taken = 1'b1;
            `LA_OP_BEQ:  e.taken = (rj == e.rkd);
            `LA_OP_BNE:  e.taken = (rj != e.rkd);
            `LA_OP_BLT:  e.taken = ($signed(rj) < $signed(e.rkd));
            `LA_OP_BGE:  e.taken = ($signed(rj) >= $signed(e.rkd));
            `LA_OP_BLTU: e.taken = (rj < e.rkd);
            `LA_OP_BGEU: e.taken = (rj >= e.rkd);
            default:     e.taken = 1'b0;
        endcase
        e.target = ((op == `LA_OP_JIRL) ? rj : r.pc) + offs;
        return e;
    endfunction

    task automatic add_row(input logic [31:0] inst, input int aop_idx, input logic [31:0] imm,
                           input logic [4:0] flags, input logic [4:0] waddr);
        row_t r;
        r       = '0;
        r.inst  = inst;
        r.pc    = 32'h1c00_0000 + n_rows * 4;
        r.eal   = 1'b1;
        r.aop   = (aop_idx < 0) ? 19'd0 : (19'd1 << aop_idx);
        r.imm   = imm;
        r.flags = flags;
        r.waddr = waddr;
        tbl[n_rows] = r;
        n_rows++;
    endtask

    // rj from the memory stage and rd from writeback
    task automatic add_branch(input logic [5:0] op, input logic [15:0] offs,
                              input logic [31:0] a, input logic [31:0] b);
        add_row(br16_inst(op, offs, 5'd20, 5'd21), -1, 32'd0, F_NONE, 5'd0);
        tbl[n_rows-1].ms = {1'b1, 5'd20, a};
        tbl[n_rows-1].ws = {1'b1, 5'd21, b};
    endtask

    task automatic expect_eq(input string name, input logic [31:0] got,
                             input logic [31:0] want);
        n_checks++;
        assert (got === want) else begin
            n_errors++;
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, want, got);
        end
    endtask

    task automatic step();
        @(posedge clk);
        if (ws_rf_collect.we && ws_rf_collect.waddr != 5'd0) begin
            shadow[ws_rf_collect.waddr] = ws_rf_collect.wdata;
        end
        #10;
    endtask

    task automatic wait_allowin();
        while (!ds_allowin) begin
            step();
        end
    endtask

    task automatic check_outputs(input row_t r, input pred_t e);
        expect_eq("ds_to_es_valid", ds_to_es_valid, 1'b1);
        expect_eq("ds_allowin", ds_allowin, 1'b1);
        expect_eq("alu_op", ds_to_es_bus.alu_op, r.aop);
        expect_eq("alu_src1", ds_to_es_bus.alu_src1, e.src1);
        expect_eq("alu_src2", ds_to_es_bus.alu_src2, e.src2);
        expect_eq("rkd_value", ds_to_es_bus.rkd_value, e.rkd);
        expect_eq("rf_we", ds_to_es_bus.rf_we, r.flags[2]);
        expect_eq("mem_we", ds_to_es_bus.mem_we, r.flags[1]);
        expect_eq("res_from_mem", ds_to_es_bus.res_from_mem, r.flags[0]);
        expect_eq("pc", ds_to_es_bus.pc, r.pc);
        if (r.flags[2]) begin
            expect_eq("rf_waddr", ds_to_es_bus.rf_waddr, r.waddr);
        end
        expect_eq("br_taken", br_collect.taken, e.taken);
        if (e.taken) begin
            expect_eq("br_target", br_collect.target, e.target);
        end
    endtask

    task automatic run_row(input row_t r);
        pred_t     e;
        ds_to_es_t held;
        wait_allowin();
        fs_to_ds_valid = 1'b1;
        fs_to_ds_bus   = {r.inst, r.pc};
        ws_rf_collect  = r.ws;
        ms_rf_collect  = r.ms;
        es_rf_collect  = r.es;
        es_allowin     = r.eal;
        step();
        e = predict(r, r.es);
        // wrong-path fetch behind a taken branch
        fs_to_ds_valid = e.taken && !e.stall;
        #40;
        if (e.stall) begin
            expect_eq("ds_to_es_valid", ds_to_es_valid, 1'b0);
            expect_eq("ds_allowin", ds_allowin, 1'b0);
            step();
            es_rf_collect = '0;
            e = predict(r, '0);
            #40;
        end
        if (!r.eal) begin
            expect_eq("ds_allowin", ds_allowin, 1'b0);
            held = ds_to_es_bus;
            step();
            n_checks++;
            assert (ds_to_es_bus === held) else begin
                n_errors++;
                $display("FAILED at %0t: ds_to_es_bus expected %h, got %h",
                         $time, held, ds_to_es_bus);
            end
            es_allowin = 1'b1;
            #40;
        end
        check_outputs(r, e);
        step();
        if (e.taken) begin
            fs_to_ds_valid = 1'b0;
            #40;
            expect_eq("ds_to_es_valid", ds_to_es_valid, 1'b0);
            step();
        end
    endtask

    initial begin
        resetn         = 1'b0;
        fs_to_ds_valid = 1'b0;
        fs_to_ds_bus   = '0;
        es_allowin     = 1'b1;
        ws_rf_collect  = '0;
        ms_rf_collect  = '0;
        es_rf_collect  = '0;
        shadow[0]      = 32'd0;
        void'($urandom(seed));

        // register read with r0 staying zero
        add_row(r3_inst(2'h1, 5'h00, 5'd3, 5'd1, 5'd2), 0, 32'd0, F_R, 5'd3);
        add_row(r3_inst(2'h1, 5'h00, 5'd4, 5'd0, 5'd31), 0, 32'd0, F_R, 5'd4);
        add_row(r3_inst(2'h1, 5'h00, 5'd5, 5'd0, 5'd0), 0, 32'd0, F_R, 5'd5);
        tbl[n_rows-1].ws = {1'b1, 5'd0, 32'hdead_beef};

        for (int i = 0; i < 18; i++) begin
            add_row(r3_inst((i < 14) ? 2'h1 : 2'h2, op3[i], 5'd7, 5'd3, 5'd9), idx3[i],
                    32'd0, F_R, 5'd7);
        end
        for (int i = 0; i < 6; i++) begin
            add_row(ri12_inst(6'h00, opi[i], 12'h9a5, 5'd3, 5'd7), idxi[i],
                    (i < 3) ? 32'hffff_f9a5 : 32'h0000_09a5, F_I, 5'd7);
        end
        for (int i = 0; i < 3; i++) begin
            add_row(ri12_inst(6'h00, 4'h1, {2'b00, ops[i], 5'd13}, 5'd3, 5'd7), 8 + i,
                    32'd13, F_I, 5'd7);
        end
        add_row(ri20_inst(`LA_OP_LU12I, 20'h8badf, 5'd7), 11, 32'h8badf000, F_I, 5'd7);
        add_row(ri20_inst(`LA_OP_PCADDU12I, 20'h12345, 5'd7), 0, 32'h12345000, F_LINK, 5'd7);
        for (int i = 0; i < 7; i++) begin
            add_row(ri12_inst(`LA_OP_MEM, opm[i], 12'hff0, 5'd3, 5'd9), 0, 32'hffff_fff0,
                    (i < 4) ? F_LD : F_ST, 5'd9);
        end

        for (int i = 0; i < 12; i++) begin
            add_branch(`LA_OP_BEQ + i / 2, (i % 2) ? 16'h0040 : 16'hfff0, bra[i], brb[i]);
        end
        add_row(br26_inst(`LA_OP_B, 26'h3ff_ff80), -1, 32'd0, F_NONE, 5'd0);
        add_row(br26_inst(`LA_OP_BL, 26'h000_0123), 0, 32'd4, F_LINK, 5'd1);
        add_row(br16_inst(`LA_OP_JIRL, 16'h0010, 5'd3, 5'd7), 0, 32'd4, F_LINK, 5'd7);

        // same register on every forward bus
        add_row(r3_inst(2'h1, 5'h00, 5'd6, 5'd10, 5'd11), 0, 32'd0, F_R, 5'd6);
        tbl[n_rows-1].es = {1'b0, 1'b1, 5'd10, 32'haaaa_0001};
        tbl[n_rows-1].ms = {1'b1, 5'd10, 32'hbbbb_0002};
        tbl[n_rows-1].ws = {1'b1, 5'd10, 32'hcccc_0003};
        add_row(r3_inst(2'h1, 5'h00, 5'd6, 5'd10, 5'd11), 0, 32'd0, F_R, 5'd6);
        tbl[n_rows-1].ms = {1'b1, 5'd11, 32'hbbbb_0004};
        tbl[n_rows-1].ws = {1'b1, 5'd11, 32'hcccc_0005};
        add_row(r3_inst(2'h1, 5'h00, 5'd6, 5'd10, 5'd11), 0, 32'd0, F_R, 5'd6);
        tbl[n_rows-1].ws = {1'b1, 5'd10, 32'hcccc_0006};

        // load-use on rk and then on rj
        add_row(r3_inst(2'h1, 5'h00, 5'd6, 5'd12, 5'd13), 0, 32'd0, F_R, 5'd6);
        tbl[n_rows-1].es = {1'b1, 1'b1, 5'd13, 32'h0bad_0bad};
        add_row(ri12_inst(`LA_OP_MEM, 4'h2, 12'hff0, 5'd12, 5'd9), 0, 32'hffff_fff0, F_LD,
                5'd9);
        tbl[n_rows-1].es = {1'b1, 1'b1, 5'd12, 32'h0bad_0bad};

        // load on the rk field of an immediate form does not stall
        add_row(ri12_inst(6'h00, 4'he, 12'h9a5, 5'd3, 5'd7), 6, 32'h0000_09a5, F_I, 5'd7);
        tbl[n_rows-1].es = {1'b1, 1'b1, 5'd5, 32'h0bad_0bad};

        add_row(r3_inst(2'h1, 5'h00, 5'd6, 5'd14, 5'd15), 0, 32'd0, F_R, 5'd6);
        tbl[n_rows-1].eal = 1'b0;

        limit = n_rows * 4 + 50;

        repeat (8) @(posedge clk);
        #10;
        resetn = 1'b1;

        // writeback preload of the register file
        for (int i = 0; i < `LA_NREG; i++) begin
            ws_rf_collect = {1'b1, 5'(i), $urandom()};
            step();
        end
        ws_rf_collect = '0;

        for (int i = 0; i < n_rows; i++) begin
            run_row(tbl[i]);
        end

        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 n_checks, n_errors, UUT.u_assert.n_fail);
        if (n_errors == 0 && UUT.u_assert.n_fail == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
